// ==== design/hist_pkg.sv ====
package hist_pkg;

  // sample and bin geometry.
  localparam int SAMPLE_W   = 12;
  localparam int BIN_ADDR_W = 4;
  localparam int NUM_BINS   = 1 << BIN_ADDR_W;

  // counts stop at all ones.
  localparam int COUNT_W = 8;

  typedef logic [SAMPLE_W-1:0]   sample_t;
  typedef logic [BIN_ADDR_W-1:0] bin_addr_t;
  typedef logic [COUNT_W-1:0]    count_t;

endpackage

// ==== design/hist_stream_if.sv ====
interface hist_stream_if #(
  parameter type payload_t = logic
);

  payload_t data;
  logic     valid;
  logic     ready;
  // marks the end of a packet on the count stream.
  logic     last;

  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// ==== design/stream_skid.sv ====
module stream_skid #(
  parameter type payload_t = logic
) (
  input  logic          aclk,
  input  logic          aresetn,
  hist_stream_if.sink   in,
  hist_stream_if.source out
);

  logic     main_valid;
  logic     main_last;
  payload_t main_data;
  logic     skid_valid;
  logic     skid_last;
  payload_t skid_data;
  logic     in_xfer;
  logic     main_free;

  // ready only depends on the spare slot, so it comes straight from a flop.
  assign in.ready  = !skid_valid;
  assign in_xfer   = in.valid && !skid_valid;
  assign main_free = !main_valid || out.ready;

  assign out.valid = main_valid;
  assign out.data  = main_data;
  assign out.last  = main_last;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (main_free)
    begin
      main_valid <= skid_valid || in_xfer;
      skid_valid <= 1'b0;
    end
    else if (in_xfer)
    begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (main_free)
    begin
      main_data <= skid_valid ? skid_data : in.data;
      main_last <= skid_valid ? skid_last : in.last;
    end
    // park the new word while the output is stalled.
    if (!main_free && in_xfer)
    begin
      skid_data <= in.data;
      skid_last <= in.last;
    end
  end

endmodule

// ==== design/hist_bram.sv ====
module hist_bram (
  input  logic               aclk,
  input  hist_pkg::bin_addr_t a_addr,
  input  hist_pkg::count_t    a_wrdata,
  input  logic               a_we,
  output hist_pkg::count_t    a_rddata,
  input  hist_pkg::bin_addr_t b_addr,
  input  hist_pkg::count_t    b_wrdata,
  input  logic               b_we,
  output hist_pkg::count_t    b_rddata
);

  import hist_pkg::*;

  count_t    mem [NUM_BINS];
  bin_addr_t a_addr_q;
  bin_addr_t b_addr_q;

  // each port reads the presented address and writes back to the address
  // it read one cycle earlier, so one port can do a full read-modify-write
  // every clock. reads return the old word when they hit a write.
  always_ff @(posedge aclk)
  begin
    a_rddata <= mem[a_addr];
    b_rddata <= mem[b_addr];
    a_addr_q <= a_addr;
    b_addr_q <= b_addr;
    if (a_we)
      mem[a_addr_q] <= a_wrdata;
    if (b_we)
      mem[b_addr_q] <= b_wrdata;
  end

endmodule

// ==== design/hist_accumulator.sv ====
module hist_accumulator (
  input  logic               aclk,
  input  logic               aresetn,
  hist_stream_if.sink        smp,
  input  logic               hold,
  output logic               idle,
  output hist_pkg::bin_addr_t a_addr,
  output hist_pkg::count_t    a_wrdata,
  output logic               a_we,
  input  hist_pkg::count_t    a_rddata
);

  import hist_pkg::*;

  logic      smp_xfer;
  bin_addr_t smp_bin;
  logic      s1_valid;
  bin_addr_t s1_bin;
  logic      s2_valid;
  bin_addr_t s2_bin;
  logic      fwd_q;
  count_t    fwd_cnt;
  count_t    old_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // intake
  ////////////////////////////////////////////////////////////////////////////

  // the bin is the top bits of the sample.
  assign smp_bin = smp.data[SAMPLE_W-1 -: BIN_ADDR_W];

  // new input is shut off upstream while held; anything already buffered
  // still drains so the pipeline can go idle.
  assign idle     = !smp.valid && !s1_valid && !s2_valid;
  assign smp.ready = !hold || !idle;
  assign smp_xfer = smp.valid && smp.ready;

  ////////////////////////////////////////////////////////////////////////////
  // read in stage 1, write in stage 2
  ////////////////////////////////////////////////////////////////////////////

  assign a_addr = s1_bin;

  // the ram read of a bin written on the same edge is stale.
  assign old_cnt  = fwd_q ? fwd_cnt : a_rddata;
  assign a_wrdata = (&old_cnt) ? old_cnt : old_cnt + 1'b1;
  assign a_we     = s2_valid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      fwd_q    <= 1'b0;
    end
    else
    begin
      s1_valid <= smp_xfer;
      s2_valid <= s1_valid;
      fwd_q    <= s1_valid && s2_valid && (s1_bin == s2_bin);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (smp_xfer)
      s1_bin <= smp_bin;
    s2_bin  <= s1_bin;
    // last value written, for a back-to-back hit on the same bin.
    fwd_cnt <= a_wrdata;
  end

endmodule

// ==== design/hist_readout.sv ====
module hist_readout (
  input  logic               aclk,
  input  logic               aresetn,
  input  logic               dump_req,
  input  logic               idle,
  output logic               hold,
  output hist_pkg::bin_addr_t b_addr,
  output hist_pkg::count_t    b_wrdata,
  output logic               b_we,
  input  hist_pkg::count_t    b_rddata,
  hist_stream_if.source      cnt
);

  import hist_pkg::*;

  typedef enum logic [1:0] {st_clear, st_run, st_dump} state_t;

  state_t    state;
  bin_addr_t ptr;
  logic      last_bin;
  logic      req_q;
  logic      issue_done;
  logic      issue;
  logic      rd_q;
  logic      wb_q;
  logic      ret_last;
  logic      pend_valid;
  logic      pend_last;
  count_t    pend_data;

  assign last_bin = (ptr == bin_addr_t'(NUM_BINS - 1));
  assign hold     = (state != st_run) || req_q;

  // only read when the word coming back is sure to have a place.
  assign issue = (state == st_dump) && !issue_done && !(cnt.valid && !cnt.ready);

  // every address read in the walk gets zeroed on the following cycle.
  assign b_addr   = ptr;
  assign b_wrdata = '0;
  assign b_we     = wb_q;

  assign cnt.valid = pend_valid || rd_q;
  assign cnt.data  = pend_valid ? pend_data : b_rddata;
  assign cnt.last  = pend_valid ? pend_last : ret_last;

  ////////////////////////////////////////////////////////////////////////////
  // clear walk and dump sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state      <= st_clear;
      ptr        <= '0;
      req_q      <= 1'b0;
      issue_done <= 1'b0;
      rd_q       <= 1'b0;
      wb_q       <= 1'b0;
      ret_last   <= 1'b0;
      pend_valid <= 1'b0;
    end
    else
    begin
      rd_q       <= issue;
      wb_q       <= issue || (state == st_clear);
      ret_last   <= issue && last_bin;
      pend_valid <= cnt.valid && !cnt.ready;
      case (state)
        st_clear:
        begin
          ptr <= ptr + 1'b1;
          if (last_bin)
            state <= st_run;
        end
        st_run:
        begin
          if (req_q && idle)
          begin
            state <= st_dump;
            req_q <= 1'b0;
          end
        end
        default:
        begin
          if (issue)
          begin
            ptr <= ptr + 1'b1;
            if (last_bin)
              issue_done <= 1'b1;
          end
          if (cnt.valid && cnt.ready && cnt.last)
          begin
            state      <= st_run;
            issue_done <= 1'b0;
          end
        end
      endcase
      // a request during clear or dump waits its turn.
      if (dump_req)
        req_q <= 1'b1;
    end
  end

  // one-deep slot for a word the out skid could not take.
  always_ff @(posedge aclk)
  begin
    if (!pend_valid)
    begin
      pend_data <= b_rddata;
      pend_last <= ret_last;
    end
  end

endmodule

// ==== design/hist_top.sv ====
module hist_top (
  input  logic             aclk,
  input  logic             aresetn,
  input  hist_pkg::sample_t s_sample_tdata,
  input  logic             s_sample_tvalid,
  output logic             s_sample_tready,
  input  logic             dump_req,
  output hist_pkg::count_t  m_count_tdata,
  output logic             m_count_tvalid,
  input  logic             m_count_tready,
  output logic             m_count_tlast
);

  import hist_pkg::*;

  hist_stream_if #(.payload_t(sample_t)) smp_raw ();
  hist_stream_if #(.payload_t(sample_t)) smp_buf ();
  hist_stream_if #(.payload_t(count_t))  cnt_raw ();
  hist_stream_if #(.payload_t(count_t))  cnt_buf ();

  bin_addr_t a_addr;
  count_t    a_wrdata;
  count_t    a_rddata;
  logic      a_we;
  bin_addr_t b_addr;
  count_t    b_wrdata;
  count_t    b_rddata;
  logic      b_we;
  logic      hold;
  logic      idle;
  logic      take_samples;

  ////////////////////////////////////////////////////////////////////////////
  // sample input
  ////////////////////////////////////////////////////////////////////////////

  // input stays closed through clear and dump, until the last count has left.
  assign take_samples    = !hold && !cnt_buf.valid;
  assign smp_raw.data    = s_sample_tdata;
  assign smp_raw.valid   = s_sample_tvalid && take_samples;
  assign smp_raw.last    = 1'b0;
  assign s_sample_tready = smp_raw.ready && take_samples;

  stream_skid #(.payload_t(sample_t)) in_skid (
    .aclk    (aclk),
    .aresetn (aresetn),
    .in      (smp_raw),
    .out     (smp_buf)
  );

  ////////////////////////////////////////////////////////////////////////////
  // counting and readout
  ////////////////////////////////////////////////////////////////////////////

  hist_accumulator u_accumulator (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .smp      (smp_buf),
    .hold     (hold),
    .idle     (idle),
    .a_addr   (a_addr),
    .a_wrdata (a_wrdata),
    .a_we     (a_we),
    .a_rddata (a_rddata)
  );

  hist_bram u_bram (
    .aclk     (aclk),
    .a_addr   (a_addr),
    .a_wrdata (a_wrdata),
    .a_we     (a_we),
    .a_rddata (a_rddata),
    .b_addr   (b_addr),
    .b_wrdata (b_wrdata),
    .b_we     (b_we),
    .b_rddata (b_rddata)
  );

  hist_readout u_readout (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .dump_req (dump_req),
    .idle     (idle),
    .hold     (hold),
    .b_addr   (b_addr),
    .b_wrdata (b_wrdata),
    .b_we     (b_we),
    .b_rddata (b_rddata),
    .cnt      (cnt_raw)
  );

  stream_skid #(.payload_t(count_t)) out_skid (
    .aclk    (aclk),
    .aresetn (aresetn),
    .in      (cnt_raw),
    .out     (cnt_buf)
  );

  assign cnt_buf.ready  = m_count_tready;
  assign m_count_tdata  = cnt_buf.data;
  assign m_count_tvalid = cnt_buf.valid;
  assign m_count_tlast  = cnt_buf.last;

endmodule

// ==== testbench/hist_assertions.sv ====
module hist_assertions (
  input logic               aclk,
  input logic               aresetn,
  input hist_pkg::sample_t  s_sample_tdata,
  input logic               s_sample_tvalid,
  input logic               s_sample_tready,
  input logic               dump_req,
  input hist_pkg::count_t   m_count_tdata,
  input logic               m_count_tvalid,
  input logic               m_count_tready,
  input logic               m_count_tlast
);

  timeunit 1ns;
  timeprecision 1ps;

  import hist_pkg::*;

  count_t      model [NUM_BINS];
  count_t      expected;
  bin_addr_t   in_bin;
  bin_addr_t   out_idx;
  logic        in_xfer;
  logic        out_xfer;
  logic        dumping;
  int          since_reset;
  logic        stall_q;
  count_t      held_data;
  logic        held_last;
  int unsigned error_count = 0;

  assign in_bin   = s_sample_tdata[SAMPLE_W-1 -: BIN_ADDR_W];
  assign in_xfer  = s_sample_tvalid && s_sample_tready;
  assign out_xfer = m_count_tvalid && m_count_tready;
  assign expected = model[out_idx];

  ////////////////////////////////////////////////////////////////////////////
  // reference model of the bin counts
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < NUM_BINS; i++)
        model[i] <= '0;
      out_idx     <= '0;
      dumping     <= 1'b0;
      since_reset <= 0;
      stall_q     <= 1'b0;
    end
    else
    begin
      if (in_xfer && !(&model[in_bin]))
        model[in_bin] <= model[in_bin] + 1'b1;
      // a bin reads back as zero once it has been sent.
      if (out_xfer)
      begin
        model[out_idx] <= '0;
        out_idx        <= out_idx + 1'b1;
      end
      if (dump_req)
        dumping <= 1'b1;
      else if (out_xfer && m_count_tlast)
        dumping <= 1'b0;
      if (since_reset < NUM_BINS)
        since_reset <= since_reset + 1;
      stall_q <= m_count_tvalid && !m_count_tready;
    end
  end

  always_ff @(posedge aclk)
  begin
    held_data <= m_count_tdata;
    held_last <= m_count_tlast;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  input_shut: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (since_reset < NUM_BINS || dumping) |-> !s_sample_tready)
  else
  begin
    error_count = error_count + 1;
    $error("input was open during the clear walk or a dump at %0t", $time);
  end

  counts_only_in_dump: assert property (
    @(posedge aclk) disable iff (!aresetn)
    m_count_tvalid |-> dumping)
  else
  begin
    error_count = error_count + 1;
    $error("a count word came out with no dump running at %0t", $time);
  end

  stalled_word_holds: assert property (
    @(posedge aclk) disable iff (!aresetn)
    stall_q |-> m_count_tvalid && m_count_tdata == held_data && m_count_tlast == held_last)
  else
  begin
    error_count = error_count + 1;
    $error("mismatch at %0t: count word changed while stalled", $time);
  end

  count_matches_model: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_xfer |-> m_count_tdata == expected)
  else
  begin
    error_count = error_count + 1;
    $error("mismatch at %0t: bin %0d gave %0d, model has %0d", $time,
      $sampled(out_idx), $sampled(m_count_tdata), $sampled(expected));
  end

  last_on_final_bin: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_xfer |-> m_count_tlast == (out_idx == bin_addr_t'(NUM_BINS - 1)))
  else
  begin
    error_count = error_count + 1;
    $error("mismatch at %0t: last flag is %0b on bin %0d", $time,
      $sampled(m_count_tlast), $sampled(out_idx));
  end

endmodule

// ==== testbench/hist_tb.sv ====
module hist_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import hist_pkg::*;

  // the tests take about a thousand cycles, the limit leaves a wide margin.
  localparam int TIMEOUT_CYCLES = 4000;

  logic        aclk;
  logic        aresetn;
  sample_t     s_sample_tdata;
  logic        s_sample_tvalid;
  logic        s_sample_tready;
  logic        dump_req;
  count_t      m_count_tdata;
  logic        m_count_tvalid;
  logic        m_count_tready;
  logic        m_count_tlast;
  logic [31:0] rand_state = 32'h6710;
  int          cycle_count = 0;

  hist_top UUT (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .s_sample_tdata  (s_sample_tdata),
    .s_sample_tvalid (s_sample_tvalid),
    .s_sample_tready (s_sample_tready),
    .dump_req        (dump_req),
    .m_count_tdata   (m_count_tdata),
    .m_count_tvalid  (m_count_tvalid),
    .m_count_tready  (m_count_tready),
    .m_count_tlast   (m_count_tlast)
  );

  bind hist_top hist_assertions count_checks (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .s_sample_tdata  (s_sample_tdata),
    .s_sample_tvalid (s_sample_tvalid),
    .s_sample_tready (s_sample_tready),
    .dump_req        (dump_req),
    .m_count_tdata   (m_count_tdata),
    .m_count_tvalid  (m_count_tvalid),
    .m_count_tready  (m_count_tready),
    .m_count_tlast   (m_count_tlast)
  );

  initial
  begin
    aclk = 1'b0;
    forever
      #20 aclk = ~aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string reason);
    $display("Something failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic send_sample(input sample_t value);
    s_sample_tdata  <= value;
    s_sample_tvalid <= 1'b1;
    do
      @(posedge aclk);
    while (!s_sample_tready);
    s_sample_tvalid <= 1'b0;
  endtask

  task automatic send_random_samples(input int count);
    for (int n = 0; n < count; n++)
    begin
      rand_state = xorshift32(rand_state);
      // an idle cycle now and then.
      if (rand_state[31:30] == 2'b00)
        @(posedge aclk);
      send_sample(rand_state[SAMPLE_W-1:0]);
    end
  endtask

  task automatic send_bin_run(input bin_addr_t bin, input int count);
    for (int n = 0; n < count; n++)
    begin
      rand_state = xorshift32(rand_state);
      send_sample({bin, rand_state[SAMPLE_W-BIN_ADDR_W-1:0]});
    end
  endtask

  task automatic run_dump(input logic random_ready);
    logic done;
    done = 1'b0;
    dump_req <= 1'b1;
    @(posedge aclk);
    dump_req <= 1'b0;
    while (!done)
    begin
      rand_state = xorshift32(rand_state);
      m_count_tready <= random_ready ? rand_state[0] : 1'b1;
      @(posedge aclk);
      done = m_count_tvalid && m_count_tready && m_count_tlast;
    end
    m_count_tready <= 1'b1;
  endtask

  always @(posedge aclk)
  begin
    cycle_count <= cycle_count + 1;
    if (UUT.count_checks.error_count != 0)
      report_failure("a check in the bound checker failed");
    else if (cycle_count >= TIMEOUT_CYCLES)
      report_failure("timeout, the tests did not finish in time");
  end

  initial
  begin
    aresetn         = 1'b0;
    s_sample_tdata  = '0;
    s_sample_tvalid = 1'b0;
    dump_req        = 1'b0;
    m_count_tready  = 1'b1;
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1;

    // input opens after the clear walk, then an empty histogram.
    while (!s_sample_tready)
      @(posedge aclk);
    run_dump(1'b0);

    send_random_samples(200);
    run_dump(1'b0);

    // back-to-back hits on one bin take the forwarding path.
    for (int r = 0; r < 8; r++)
    begin
      rand_state = xorshift32(rand_state);
      send_bin_run(rand_state[BIN_ADDR_W-1:0], 2 + int'(rand_state[6:4]));
    end
    run_dump(1'b0);

    send_bin_run(bin_addr_t'(9), 300);
    send_random_samples(40);
    run_dump(1'b1);

    send_random_samples(100);
    run_dump(1'b1);

    // nothing new since the last dump.
    run_dump(1'b0);

    repeat (4) @(posedge aclk);
    if (UUT.count_checks.error_count == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      report_failure("a check in the bound checker failed");
    end
  end

endmodule

// ==== hist_top.f ====
design/hist_pkg.sv
design/hist_stream_if.sv
design/stream_skid.sv
design/hist_bram.sv
design/hist_accumulator.sv
design/hist_readout.sv
design/hist_top.sv
testbench/hist_assertions.sv
testbench/hist_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module hist_tb \
  -f hist_top.f -o hist_sim \
  && ./obj_dir/hist_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
